// File: verilog/swin_pkg.sv
// shared sizes, encodings and bus structs of the sliding-window scatter unit
// imported by every RTL stage and by the bench
`default_nettype none

package swin_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int PIX_W    = 8;                   // bits per pixel
   localparam int BEAT_PIX = 16;                  // pixels per input beat
   localparam int BANK_PIX = 8;                   // pixels per bank
   localparam int N_BANKS  = 3;                   // banks in a group
   localparam int WIN_PIX  = N_BANKS * BANK_PIX;  // 24-pixel window
   localparam int PAD_PIX  = WIN_PIX - BEAT_PIX;  // unused window slots per beat
   localparam int N_GROUPS = 3;

   localparam int CONF_ADDR_W = 9;
   localparam int CONF_DATA_W = 19;

   // config word field widths
   localparam int OFFSET_W = 3;
   localparam int ORDER_W  = 3;
   localparam int CYCLE_W  = 8;
   localparam int SPLIT_W  = CONF_DATA_W - OFFSET_W - ORDER_W - CYCLE_W - 1;

   // first segment goes to group 1
   localparam logic [N_GROUPS-1:0] GRP_FIRST = 3'b010;

   // ------------------------------
   // enums
   // ------------------------------
   typedef enum logic [1:0] {
      ROT0 = 2'd0,   // no bank shift
      ROT1 = 2'd1,   // one bank up
      ROT2 = 2'd2    // two banks up
   } rot_e;

   typedef enum logic [1:0] {
      FETCH_WAIT = 2'd0,  // memory still reading entry 0
      FETCH_LOAD = 2'd1,  // entry 0 on the read port
      RUN        = 2'd2
   } fetch_state_e;

   // ------------------------------
   // structs
   // ------------------------------
   typedef struct packed {
      logic [SPLIT_W-1:0]  split;   // line-end split, not used here
      logic                ret;     // next address is 0
      logic [CYCLE_W-1:0]  cycle;   // beats in segment minus one
      logic [ORDER_W-1:0]  order;   // starting rotation, mod 3
      logic [OFFSET_W-1:0] offset;  // pixel offset in window
   } cfg_word_t;

   typedef struct packed {
      logic                valid;
      logic [OFFSET_W-1:0] offset;
      rot_e                rot;
      logic [N_GROUPS-1:0] group;     // one-hot
      logic                seg_last;  // beat closes its segment
   } beat_cmd_t;

   typedef logic [BEAT_PIX-1:0][PIX_W-1:0] beat_pix_t;

   typedef struct packed {
      logic [WIN_PIX-1:0][PIX_W-1:0] data;
      logic [WIN_PIX-1:0]            mask;  // one bit per pixel
      logic [N_BANKS-1:0]            inc;   // per-bank address step
   } win_t;

   typedef struct packed {
      logic [WIN_PIX-1:0][PIX_W-1:0] data;
      logic [WIN_PIX-1:0]            mask;
      logic [N_BANKS-1:0]            inc;
   } group_wr_t;

   // ------------------------------
   // rotation helpers
   // ------------------------------
   function automatic rot_e rot_of_order(input logic [ORDER_W-1:0] order);
      case (order)
         3'd0, 3'd3, 3'd6: return ROT0;
         3'd1, 3'd4, 3'd7: return ROT1;
         default:          return ROT2;
      endcase
   endfunction

   function automatic rot_e rot_next(input rot_e r);
      case (r)
         ROT0:    return ROT1;
         ROT1:    return ROT2;
         default: return ROT0;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: verilog/cfg_decode.sv
// walks the configuration table and stamps every accepted beat with
// offset, bank rotation and target group; one cycle from accept to cmd
`default_nettype none

module cfg_decode
   import swin_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  beat_pix_t              in_pix,
   input  cfg_word_t              conf_rd_data,
   output logic                   in_ready,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output beat_cmd_t              cmd,
   output beat_pix_t              cmd_pix
);

   fetch_state_e           state;
   cfg_word_t              cur;       // entry of the running segment
   logic [CONF_ADDR_W-1:0] addr_q;    // address whose entry sits on conf_rd_data
   logic [CONF_ADDR_W-1:0] addr_nxt;
   logic [CYCLE_W-1:0]     beat_cnt;  // beats done in this segment
   rot_e                   rot;
   logic [N_GROUPS-1:0]    grp;
   logic                   accept;
   logic                   seg_last;
   logic                   load;

   assign in_ready = (state == RUN);
   assign accept   = in_valid && in_ready;
   assign seg_last = (beat_cnt == cur.cycle);

   // entry on the read port becomes current
   assign load = (state == FETCH_LOAD) || (accept && seg_last);

   // ------------------------------
   // config address
   // ------------------------------
   assign addr_nxt = conf_rd_data.ret ? '0 : addr_q + 1'b1;

   // the next address goes out in the load cycle, so the entry after it
   // is already on the port for a one-beat segment right behind
   assign conf_rd_addr = load ? addr_nxt : addr_q;

   // ------------------------------
   // start-up fetch
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= FETCH_WAIT;
      end else begin
         case (state)
            FETCH_WAIT: state <= FETCH_LOAD;
            FETCH_LOAD: state <= RUN;
            RUN:        state <= RUN;
            default:    state <= FETCH_WAIT;
         endcase
      end
   end

   // ------------------------------
   // segment sequencing
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q   <= '0;
         cur      <= '0;
         beat_cnt <= '0;
         rot      <= ROT0;
         grp      <= GRP_FIRST;
      end else begin
         if (load) begin
            addr_q   <= addr_nxt;
            cur      <= conf_rd_data;
            rot      <= rot_of_order(conf_rd_data.order);  // restart rotation
            beat_cnt <= '0;
         end else if (accept) begin
            rot      <= rot_next(rot);
            beat_cnt <= beat_cnt + 1'b1;
         end
         // group pointer moves up 1 -> 2 -> 0
         if (accept && seg_last) begin
            grp <= {grp[N_GROUPS-2:0], grp[N_GROUPS-1]};
         end
      end
   end

   // ------------------------------
   // beat command
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd <= '0;
      end else begin
         cmd.valid    <= accept;
         cmd.offset   <= cur.offset;
         cmd.rot      <= rot;
         cmd.group    <= grp;
         cmd.seg_last <= seg_last;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_pix <= in_pix;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pixel_place.sv
// drops a 16-pixel beat into the 24-pixel window at its offset, then
// rotates data and mask by whole banks; registered, one cycle
`default_nettype none

module pixel_place
   import swin_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  beat_cmd_t           cmd,
   input  beat_pix_t           cmd_pix,
   output win_t                win,
   output logic [N_GROUPS-1:0] win_group,
   output logic                win_valid
);

   logic [WIN_PIX-1:0][PIX_W-1:0] place_data;
   logic [WIN_PIX-1:0][PIX_W-1:0] rot_data;
   logic [WIN_PIX-1:0]            place_mask;
   logic [WIN_PIX-1:0]            rot_mask;
   logic [N_BANKS-1:0]            inc;

   // ------------------------------
   // offset placement
   // ------------------------------
   always_comb begin
      place_data = {{(PAD_PIX*PIX_W){1'b0}}, cmd_pix} << (cmd.offset * PIX_W);
      place_mask = {{PAD_PIX{1'b0}}, {BEAT_PIX{1'b1}}} << cmd.offset;
   end

   // ------------------------------
   // bank rotation
   // ------------------------------
   // pixel p lands on (p + 8*rot) mod 24, mask follows its pixel
   always_comb begin
      case (cmd.rot)
         ROT1: begin
            rot_data = {place_data[WIN_PIX-BANK_PIX-1:0],
                        place_data[WIN_PIX-1:WIN_PIX-BANK_PIX]};
            rot_mask = {place_mask[WIN_PIX-BANK_PIX-1:0],
                        place_mask[WIN_PIX-1:WIN_PIX-BANK_PIX]};
         end
         ROT2: begin
            rot_data = {place_data[BANK_PIX-1:0], place_data[WIN_PIX-1:BANK_PIX]};
            rot_mask = {place_mask[BANK_PIX-1:0], place_mask[WIN_PIX-1:BANK_PIX]};
         end
         default: begin
            rot_data = place_data;
            rot_mask = place_mask;
         end
      endcase
   end

   // bank fills its top pixel -> step that bank's address
   always_comb begin
      for (int b = 0; b < N_BANKS; b++) begin
         inc[b] = rot_mask[b*BANK_PIX + BANK_PIX - 1];
      end
   end

   // ------------------------------
   // output register
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         win_valid <= 1'b0;
         win_group <= '0;
      end else begin
         win_valid <= cmd.valid;
         win_group <= cmd.group;
      end
   end

   always_ff @(posedge clk) begin
      win.data <= rot_data;
      win.mask <= rot_mask;
      win.inc  <= inc;
   end

endmodule

`default_nettype wire

// File: verilog/group_route.sv
// steers the placed window onto the lane of its bank group and registers
// the block-RAM write outputs; idle lanes are driven all zero
`default_nettype none

module group_route
   import swin_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  win_t                win,
   input  logic [N_GROUPS-1:0] win_group,
   input  logic                win_valid,
   output group_wr_t           wr_port [N_GROUPS],
   output logic [N_GROUPS-1:0] wr_group_en
);

   group_wr_t           lane_d [N_GROUPS];
   logic [N_GROUPS-1:0] en_d;

   // ------------------------------
   // lane select
   // ------------------------------
   assign en_d = win_valid ? win_group : '0;

   always_comb begin
      for (int g = 0; g < N_GROUPS; g++) begin
         lane_d[g] = '0;
         if (en_d[g]) begin
            lane_d[g].data = win.data;
            lane_d[g].mask = win.mask;
            lane_d[g].inc  = win.inc;
         end
      end
   end

   // ------------------------------
   // write register
   // ------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int g = 0; g < N_GROUPS; g++) begin
            wr_port[g] <= '0;
         end
         wr_group_en <= '0;
      end else begin
         for (int g = 0; g < N_GROUPS; g++) begin
            wr_port[g] <= lane_d[g];  // zero unless this group is written
         end
         wr_group_en <= en_d;
      end
   end

endmodule

`default_nettype wire

// File: verilog/swin_decoder.sv
// top of the scatter unit: config decode, pixel placement, group routing
// a beat accepted at edge n shows on the write ports after edge n+2
`default_nettype none

module swin_decoder
   import swin_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  beat_pix_t              in_pix,
   input  cfg_word_t              conf_rd_data,
   output logic                   in_ready,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output group_wr_t              wr_port [N_GROUPS],
   output logic [N_GROUPS-1:0]    wr_group_en
);

   beat_cmd_t           cmd;
   beat_pix_t           cmd_pix;
   win_t                win;
   logic [N_GROUPS-1:0] win_group;
   logic                win_valid;

   cfg_decode u_cfg_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_pix       (in_pix),
      .conf_rd_data (conf_rd_data),
      .in_ready     (in_ready),
      .conf_rd_addr (conf_rd_addr),
      .cmd          (cmd),
      .cmd_pix      (cmd_pix)
   );

   pixel_place u_pixel_place (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .cmd_pix   (cmd_pix),
      .win       (win),
      .win_group (win_group),
      .win_valid (win_valid)
   );

   group_route u_group_route (
      .clk         (clk),
      .rst_n       (rst_n),
      .win         (win),
      .win_group   (win_group),
      .win_valid   (win_valid),
      .wr_port     (wr_port),
      .wr_group_en (wr_group_en)
   );

endmodule

`default_nettype wire

// File: bench/swin_model.svh
// reference model for the scatter unit bench: window placement, bank shift,
// increments, group order and the stimulus LFSR; included ahead of the bench
`ifndef SWIN_MODEL_SVH
`define SWIN_MODEL_SVH
`default_nettype none

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// ------------------------------
// expected window of one beat
// ------------------------------
// each output position looks back to where its pixel sat before the shift
function automatic swin_pkg::win_t expect_window(input int offset, input int rot,
                                                 input swin_pkg::beat_pix_t pix);
   swin_pkg::win_t w;
   int src;
   w = '0;
   for (int p = 0; p < swin_pkg::WIN_PIX; p++) begin
      src = (p + swin_pkg::WIN_PIX - swin_pkg::BANK_PIX * rot) % swin_pkg::WIN_PIX;
      if (src >= offset && src < offset + swin_pkg::BEAT_PIX) begin
         w.data[p] = pix[src - offset];
         w.mask[p] = 1'b1;
      end
   end
   for (int b = 0; b < swin_pkg::N_BANKS; b++) begin
      w.inc[b] = w.mask[swin_pkg::BANK_PIX * b + swin_pkg::BANK_PIX - 1];  // top pixel
   end
   return w;
endfunction

// group order 1 -> 2 -> 0
function automatic logic [2:0] next_group(input logic [2:0] g);
   case (g)
      3'b010:  return 3'b100;
      3'b100:  return 3'b001;
      default: return 3'b010;
   endcase
endfunction

`default_nettype wire
`endif

// File: bench/swin_tb.sv
// self-checking bench for the scatter unit with a config ROM model and LFSR beats
// the scoreboard retires one beat per enabled write and reports per test
`include "swin_model.svh"
`default_nettype none

module swin_tb
   import swin_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   typedef enum int {T_RESET, T_PLACE, T_ROT, T_GROUP, T_CONF, T_STREAM} test_e;

   typedef struct {
      logic [N_GROUPS-1:0] grp;
      win_t                win;
      int                  due;  // negedge count at which the write shows
   } exp_item_t;

   logic clk, rst_n, in_valid, in_ready;
   beat_pix_t in_pix;
   cfg_word_t conf_rd_data;
   logic [CONF_ADDR_W-1:0] conf_rd_addr;
   group_wr_t wr_port [N_GROUPS];
   logic [N_GROUPS-1:0] wr_group_en;

   cfg_word_t cfg_mem [6];
   logic [1:0] rnd_cycle [6];
   logic [3:0] rnd_split [6];
   int entry_lap [6];
   int off_base, ord_base;
   logic [31:0] lfsr;

   exp_item_t sb [$];
   cfg_word_t m_cur;        // model copy of the running entry
   int m_idx, m_cnt, m_rot, m_loads, returns, beats, writes, cyc;
   logic [2:0] m_grp;
   logic [7:0] seen_off, seen_ord;
   logic four_done;
   int chk_cnt [6];
   int err_cnt [6];
   string test_name [6] = '{"reset", "placement", "rotation", "groups", "config", "stream"};

   swin_decoder uut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // config ROM with one cycle of read latency
   always @(posedge clk) begin
      conf_rd_data <= (conf_rd_addr < 6) ? cfg_mem[conf_rd_addr] : '0;
   end

   // ------------------------------
   // check helpers
   // ------------------------------
   task automatic check_eq(input int t, input string name, input logic [255:0] got,
                           input logic [255:0] exp);
      chk_cnt[t]++;
      assert (got === exp) else begin
         err_cnt[t]++;
         $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input int t, input logic ok, input string what);
      chk_cnt[t]++;
      assert (ok) else begin
         err_cnt[t]++;
         $display("** Error at %0t ns: %s", $time, what);
      end
   endtask

   task automatic draw_bits(input int n, output logic [127:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[126:0], lfsr[0]};  // one step per bit
      end
   endtask

   // offsets and orders step through all 8 values over two laps
   function automatic cfg_word_t make_entry(input int i, input int lap);
      cfg_word_t e;
      e        = '0;
      e.offset = (off_base + i + 6 * lap) % 8;
      e.order  = (ord_base + i + 6 * lap) % 8;
      e.cycle  = rnd_cycle[i];
      e.ret    = (i == 5);
      e.split  = rnd_split[i];
      return e;
   endfunction

   function automatic int next_addr(input int a);
      return cfg_mem[a].ret ? 0 : a + 1;
   endfunction

   task automatic check_reset_outputs();
      check_eq(T_RESET, "in_ready", in_ready, 1'b0);
      check_eq(T_RESET, "wr_group_en", wr_group_en, '0);
      check_eq(T_RESET, "conf_rd_addr", conf_rd_addr, '0);
      for (int g = 0; g < N_GROUPS; g++) begin
         check_eq(T_RESET, $sformatf("wr_port[%0d].mask", g), wr_port[g].mask, '0);
         check_eq(T_RESET, $sformatf("wr_port[%0d].inc", g), wr_port[g].inc, '0);
      end
   endtask

   // ------------------------------
   // scoreboard and model
   // ------------------------------
   task automatic check_outputs();
      exp_item_t it;
      logic [N_GROUPS-1:0] exp_en;
      exp_en = '0;
      if (sb.size() > 0 && sb[0].due == cyc) begin
         it     = sb[0];
         exp_en = it.grp;
      end
      check_eq(T_GROUP, "wr_group_en", wr_group_en, exp_en);
      if (wr_group_en != '0) begin
         writes++;
         if (sb.size() > 0) begin
            sb.delete(0);  // a write retires the oldest beat
         end
      end
      for (int g = 0; g < N_GROUPS; g++) begin
         if (exp_en[g]) begin
            check_eq(T_PLACE, $sformatf("wr_port[%0d].data", g), wr_port[g].data, it.win.data);
            check_eq(T_PLACE, $sformatf("wr_port[%0d].mask", g), wr_port[g].mask, it.win.mask);
            check_eq(T_ROT, $sformatf("wr_port[%0d].inc", g), wr_port[g].inc, it.win.inc);
         end else begin
            check_eq(T_PLACE, $sformatf("wr_port[%0d]", g), wr_port[g], '0);  // idle lane
         end
      end
   endtask

   task automatic model_load(input int idx);
      m_idx = idx;
      m_cur = cfg_mem[idx];
      m_rot = m_cur.order % 3;
      m_cnt = 0;
      m_loads++;
      seen_ord[m_cur.order] = 1'b1;
   endtask

   task automatic model_cycle();
      logic acc;
      logic last;
      int prev;
      exp_item_t it;
      acc  = in_valid;
      last = (m_cnt == m_cur.cycle);
      check_eq(T_CONF, "conf_rd_addr", conf_rd_addr,
               (acc && last) ? next_addr(next_addr(m_idx)) : next_addr(m_idx));
      check_eq(T_CONF, "in_ready", in_ready, 1'b1);
      if (acc) begin
         it.grp = m_grp;
         it.win = expect_window(m_cur.offset, m_rot, in_pix);
         it.due = cyc + 3;  // accept edge plus two
         sb.push_back(it);
         beats++;
         seen_off[m_cur.offset] = 1'b1;
         if (last) begin
            if (m_cur.cycle == 3) four_done = 1'b1;
            prev  = m_idx;
            m_grp = next_group(m_grp);
            if (next_addr(m_idx) == 0) returns++;
            model_load(next_addr(m_idx));
            entry_lap[prev]++;
            cfg_mem[prev] = make_entry(prev, entry_lap[prev]);  // used on its next lap
         end else begin
            m_rot = (m_rot + 1) % 3;
            m_cnt++;
         end
      end
   endtask

   task automatic step_cycle(input logic valid);
      logic [127:0] r;
      @(posedge clk);
      in_valid <= valid;
      if (valid) begin
         draw_bits(128, r);
         in_pix <= r;
      end
      @(negedge clk);
      cyc++;
      check_outputs();
      model_cycle();
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      logic [127:0] r;
      int n;
      int total_err;
      int total_chk;
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      in_pix       = '0;
      conf_rd_data = '0;
      lfsr         = 32'hc8a1_f459;
      m_grp        = 3'b010;  // first segment goes to group 1
      seen_off     = '0;
      seen_ord     = '0;
      four_done    = 1'b0;
      draw_bits(3, r);
      off_base = r[2:0];
      draw_bits(3, r);
      ord_base = r[2:0];
      for (int i = 0; i < 6; i++) begin
         draw_bits(2, r);
         rnd_cycle[i] = r[1:0];
         draw_bits(4, r);
         rnd_split[i] = r[3:0];
      end
      rnd_cycle[1] = 2'd0;  // one-beat segment
      rnd_cycle[3] = 2'd3;  // four-beat segment
      for (int i = 0; i < 6; i++) cfg_mem[i] = make_entry(i, 0);

      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         check_reset_outputs();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_reset_outputs();
      n = 0;
      while (in_ready !== 1'b1 && n < 16) begin
         @(negedge clk);
         n++;
      end
      if (in_ready !== 1'b1) begin
         $display("in_ready stayed low for 16 cycles after reset release");
         $display("Simulation failed");
         $finish;
      end
      $display("test %s: %0d checks, %0d errors", test_name[T_RESET],
               chk_cnt[T_RESET], err_cnt[T_RESET]);

      model_load(0);
      check_outputs();
      model_cycle();
      for (int i = 0; i < 16; i++) step_cycle(1'b1);  // back-to-back
      n = 0;
      while (m_loads < 14 && n < 400) begin
         draw_bits(2, r);
         step_cycle(r[1:0] != 2'b00);  // about one gap in four
         n++;
      end
      n = 0;
      while ((sb.size() > 0 || n < 3) && n < 10) begin
         step_cycle(1'b0);
         n++;
      end

      check_true(T_PLACE, seen_off == 8'hff, "not every offset value was exercised");
      check_true(T_ROT, seen_ord == 8'hff, "not every order value was loaded");
      check_true(T_ROT, four_done, "no four-beat segment was completed");
      check_true(T_CONF, returns >= 2, "configuration table was not walked twice");
      check_true(T_STREAM, sb.size() == 0, "scoreboard still holds beats after draining");
      check_eq(T_STREAM, "enabled write count", writes, beats);
      for (int t = T_PLACE; t <= T_STREAM; t++) begin
         $display("test %s: %0d checks, %0d errors", test_name[t], chk_cnt[t], err_cnt[t]);
      end
      total_err = 0;
      total_chk = 0;
      for (int t = 0; t < 6; t++) begin
         total_err += err_cnt[t];
         total_chk += chk_cnt[t];
      end
      $display("total: %0d checks, %0d errors, %0d beats", total_chk, total_err, beats);
      if (total_err == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+bench
verilog/swin_pkg.sv
verilog/cfg_decode.sv
verilog/pixel_place.sv
verilog/group_route.sv
verilog/swin_decoder.sv
bench/swin_tb.sv

// File: Bender.yml
package:
  name: swin_decoder

sources:
  - verilog/swin_pkg.sv
  - verilog/cfg_decode.sv
  - verilog/pixel_place.sv
  - verilog/group_route.sv
  - verilog/swin_decoder.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/swin_tb.sv
